// ==== design/soc_consts.svh ====
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

//==========================================================================
// Bus geometry
//==========================================================================

`define SOC_ADDR_WIDTH 32
`define SOC_DATA_WIDTH 32
`define SOC_REGION_WIDTH 4
`define SOC_ADDR_LSH 2

// Top address nibble of each mapped device
`define SOC_REGION_RAM 4'h1
`define SOC_REGION_LED 4'h4
`define SOC_REGION_TIMER 4'hA

//==========================================================================
// Device sizes
//==========================================================================

`define SOC_RAM_WORDS 512
`define SOC_LED_WIDTH 10

// Timer register map, in words
`define SOC_TIMER_REG_WIDTH 3
`define SOC_TIMER_REG_COUNT 0
`define SOC_TIMER_REG_COMPARE 1

`endif

// ==== design/soc_bus_pkg.sv ====
`default_nettype none

`include "soc_consts.svh"

package soc_bus_pkg;

	// Bus side
	typedef logic [`SOC_ADDR_WIDTH-1:0] bus_addr_t;
	typedef logic [`SOC_DATA_WIDTH-1:0] bus_data_t;
	typedef logic [`SOC_REGION_WIDTH-1:0] region_t;

	// RAM word index, sized from the depth
	typedef logic [$clog2(`SOC_RAM_WORDS)-1:0] ram_index_t;

	// Timer register offset, address bits 4 to 2
	typedef logic [`SOC_TIMER_REG_WIDTH-1:0] timer_reg_t;

	// LED pattern
	typedef logic [`SOC_LED_WIDTH-1:0] led_value_t;

endpackage

`default_nettype wire

// ==== design/soc_bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module soc_bus_decode
	import soc_bus_pkg::*;
(
	input  wire logic       i_bus_request,
	input  wire bus_addr_t  i_bus_address,

	output logic            o_ram_request,
	output logic            o_led_request,
	output logic            o_timer_request,
	output logic            o_unmapped_request,

	output ram_index_t      o_ram_index,
	output timer_reg_t      o_timer_reg,

	output logic            o_ram_select,
	output logic            o_timer_select
);

	region_t region;
	logic ram_hit;
	logic led_hit;
	logic timer_hit;

	//==========================================================================
	// Region match on the top nibble
	//==========================================================================

	assign region = i_bus_address[`SOC_ADDR_WIDTH-1 -: `SOC_REGION_WIDTH];

	assign ram_hit = (region == `SOC_REGION_RAM);
	assign led_hit = (region == `SOC_REGION_LED);
	assign timer_hit = (region == `SOC_REGION_TIMER);

	// Selects stay ungated so the read mux holds through the ready cycle
	assign o_ram_select = ram_hit;
	assign o_timer_select = timer_hit;

	// Per-device request strobes
	assign o_ram_request = i_bus_request && ram_hit;
	assign o_led_request = i_bus_request && led_hit;
	assign o_timer_request = i_bus_request && timer_hit;

	// Nothing claimed this address
	assign o_unmapped_request = i_bus_request && !(ram_hit || led_hit || timer_hit);

	//==========================================================================
	// Word offsets
	//==========================================================================

	assign o_ram_index = i_bus_address[`SOC_ADDR_LSH +: $bits(ram_index_t)];
	assign o_timer_reg = i_bus_address[`SOC_ADDR_LSH +: $bits(timer_reg_t)];

endmodule

`default_nettype wire

// ==== design/soc_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module soc_ram
	import soc_bus_pkg::*;
(
	input  wire logic       i_clock,
	input  wire logic       i_rst,

	input  wire logic       i_request,
	input  wire logic       i_rw,
	input  wire ram_index_t i_index,
	input  wire bus_data_t  i_wdata,
	output bus_data_t       o_rdata,
	output logic            o_ready
);

	bus_data_t mem [`SOC_RAM_WORDS];
	logic accept;

	// Held request is taken once, the ready cycle blocks a second take
	assign accept = i_request && !o_ready;

	// Storage and registered read port
	always_ff @(posedge i_clock) begin
		if (accept) begin
			if (i_rw) begin
				mem[i_index] <= i_wdata;
			end else begin
				o_rdata <= mem[i_index];
			end
		end
	end

	// One-cycle acknowledge
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_ready <= 1'b0;
		end else begin
			o_ready <= accept;
		end
	end

endmodule

`default_nettype wire

// ==== design/soc_led.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module soc_led
	import soc_bus_pkg::*;
(
	input  wire logic      i_clock,
	input  wire logic      i_rst,

	input  wire logic      i_request,
	input  wire logic      i_rw,
	input  wire bus_data_t i_wdata,
	output logic           o_ready,

	output led_value_t     o_leds
);

	logic accept;

	assign accept = i_request && !o_ready;

	// Write-only register, reads just get acknowledged
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_ready <= 1'b0;
			o_leds <= '0;
		end else begin
			o_ready <= accept;
			if (accept && i_rw)
				o_leds <= i_wdata[`SOC_LED_WIDTH-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== design/soc_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module soc_timer
	import soc_bus_pkg::*;
(
	input  wire logic       i_clock,
	input  wire logic       i_rst,

	input  wire logic       i_request,
	input  wire logic       i_rw,
	input  wire timer_reg_t i_reg,
	input  wire bus_data_t  i_wdata,
	output bus_data_t       o_rdata,
	output logic            o_ready,

	output logic            o_interrupt
);

	bus_data_t count;
	bus_data_t compare;
	logic accept;

	assign accept = i_request && !o_ready;

	//==========================================================================
	// Count, compare and interrupt level
	//==========================================================================

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_ready <= 1'b0;
			o_interrupt <= 1'b0;
			count <= '0;
			compare <= '1;
		end else begin
			o_ready <= accept;
			o_interrupt <= (count >= compare);

			// A count write replaces this cycle's increment
			if (accept && i_rw && i_reg == timer_reg_t'(`SOC_TIMER_REG_COUNT))
				count <= i_wdata;
			else
				count <= count + 1'b1;

			if (accept && i_rw && i_reg == timer_reg_t'(`SOC_TIMER_REG_COMPARE))
				compare <= i_wdata;
		end
	end

	// Read data for the ready cycle, unused offsets give zero
	always_ff @(posedge i_clock) begin
		if (accept && !i_rw) begin
			case (i_reg)
				timer_reg_t'(`SOC_TIMER_REG_COUNT):   o_rdata <= count;
				timer_reg_t'(`SOC_TIMER_REG_COMPARE): o_rdata <= compare;
				default:                              o_rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/soc_bus_return.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_return
	import soc_bus_pkg::*;
(
	input  wire logic      i_clock,
	input  wire logic      i_rst,

	input  wire bus_addr_t i_bus_address,
	input  wire logic      i_unmapped_request,
	input  wire logic      i_ram_select,
	input  wire logic      i_timer_select,

	input  wire bus_data_t i_ram_rdata,
	input  wire bus_data_t i_timer_rdata,
	input  wire logic      i_ram_ready,
	input  wire logic      i_led_ready,
	input  wire logic      i_timer_ready,

	output bus_data_t      o_bus_rdata,
	output logic           o_bus_ready,
	output logic           o_bus_fault,
	output bus_addr_t      o_fault_address
);

	logic unmapped_ready;
	logic unmapped_accept;

	//==========================================================================
	// Read data and ready merge
	//==========================================================================

	// LED and unmapped reads fall through to zero
	assign o_bus_rdata =
		i_ram_select   ? i_ram_rdata   :
		i_timer_select ? i_timer_rdata :
		'0;

	assign o_bus_ready = i_ram_ready | i_led_ready | i_timer_ready | unmapped_ready;

	//==========================================================================
	// Unmapped reply and sticky fault
	//==========================================================================

	assign unmapped_accept = i_unmapped_request && !unmapped_ready;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			unmapped_ready <= 1'b0;
			o_bus_fault <= 1'b0;
			o_fault_address <= '0;
		end else begin
			unmapped_ready <= unmapped_accept;
			// Only the first faulting address is kept
			if (unmapped_accept && !o_bus_fault) begin
				o_bus_fault <= 1'b1;
				o_fault_address <= i_bus_address;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top
	import soc_bus_pkg::*;
(
	input  wire logic      i_clock,
	input  wire logic      i_rst,

	// Master side
	input  wire logic      i_bus_request,
	input  wire logic      i_bus_rw,
	input  wire bus_addr_t i_bus_address,
	input  wire bus_data_t i_bus_wdata,
	output bus_data_t      o_bus_rdata,
	output logic           o_bus_ready,

	// Device pins
	output led_value_t     o_leds,
	output logic           o_timer_interrupt,

	// Fault report
	output logic           o_bus_fault,
	output bus_addr_t      o_fault_address
);

	logic ram_request;
	logic led_request;
	logic timer_request;
	logic unmapped_request;
	ram_index_t ram_index;
	timer_reg_t timer_reg;
	logic ram_select;
	logic timer_select;

	bus_data_t ram_rdata;
	bus_data_t timer_rdata;
	logic ram_ready;
	logic led_ready;
	logic timer_ready;

	//==========================================================================
	// Address decode
	//==========================================================================

	soc_bus_decode decode (
		.i_bus_request      (i_bus_request),
		.i_bus_address      (i_bus_address),
		.o_ram_request      (ram_request),
		.o_led_request      (led_request),
		.o_timer_request    (timer_request),
		.o_unmapped_request (unmapped_request),
		.o_ram_index        (ram_index),
		.o_timer_reg        (timer_reg),
		.o_ram_select       (ram_select),
		.o_timer_select     (timer_select)
	);

	//==========================================================================
	// Devices
	//==========================================================================

	soc_ram ram (
		.i_clock   (i_clock),
		.i_rst     (i_rst),
		.i_request (ram_request),
		.i_rw      (i_bus_rw),
		.i_index   (ram_index),
		.i_wdata   (i_bus_wdata),
		.o_rdata   (ram_rdata),
		.o_ready   (ram_ready)
	);

	soc_led led (
		.i_clock   (i_clock),
		.i_rst     (i_rst),
		.i_request (led_request),
		.i_rw      (i_bus_rw),
		.i_wdata   (i_bus_wdata),
		.o_ready   (led_ready),
		.o_leds    (o_leds)
	);

	soc_timer timer (
		.i_clock     (i_clock),
		.i_rst       (i_rst),
		.i_request   (timer_request),
		.i_rw        (i_bus_rw),
		.i_reg       (timer_reg),
		.i_wdata     (i_bus_wdata),
		.o_rdata     (timer_rdata),
		.o_ready     (timer_ready),
		.o_interrupt (o_timer_interrupt)
	);

	// Reply merge, also answers unmapped requests
	soc_bus_return bus_return (
		.i_clock            (i_clock),
		.i_rst              (i_rst),
		.i_bus_address      (i_bus_address),
		.i_unmapped_request (unmapped_request),
		.i_ram_select       (ram_select),
		.i_timer_select     (timer_select),
		.i_ram_rdata        (ram_rdata),
		.i_timer_rdata      (timer_rdata),
		.i_ram_ready        (ram_ready),
		.i_led_ready        (led_ready),
		.i_timer_ready      (timer_ready),
		.o_bus_rdata        (o_bus_rdata),
		.o_bus_ready        (o_bus_ready),
		.o_bus_fault        (o_bus_fault),
		.o_fault_address    (o_fault_address)
	);

endmodule

`default_nettype wire

// ==== verif/soc_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_checker
	import soc_bus_pkg::*;
(
	input wire logic      i_clock,
	input wire logic      i_rst,
	input wire logic      i_bus_request,
	input wire logic      o_bus_ready,
	input wire logic      o_bus_fault,
	input wire bus_addr_t o_fault_address
);

	//==========================================================================
	// Bus handshake
	//==========================================================================

	// Ready is a single-cycle pulse
	assert property (@(posedge i_clock) disable iff (i_rst) o_bus_ready |=> !o_bus_ready)
		else $error("ready high two cycles in a row");

	// A new request is answered one cycle later
	assert property (@(posedge i_clock) disable iff (i_rst)
		$rose(i_bus_request) |=> o_bus_ready)
		else $error("ready missing one cycle after request");

	//==========================================================================
	// Fault report
	//==========================================================================

	assert property (@(posedge i_clock) disable iff (i_rst) o_bus_fault |=> o_bus_fault)
		else $error("fault flag dropped without reset");

	assert property (@(posedge i_clock) disable iff (i_rst)
		o_bus_fault |=> $stable(o_fault_address))
		else $error("fault address changed while fault set");

endmodule

bind soc_top soc_checker checker_inst (
	.i_clock         (i_clock),
	.i_rst           (i_rst),
	.i_bus_request   (i_bus_request),
	.o_bus_ready     (o_bus_ready),
	.o_bus_fault     (o_bus_fault),
	.o_fault_address (o_fault_address)
);

`default_nettype wire

// ==== verif/soc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module soc_tb
	import soc_bus_pkg::*;
;

	localparam int NUM_TRANSFERS = 300;
	localparam int CYCLE_LIMIT = 10 * NUM_TRANSFERS * 4;

	logic i_clock;
	logic i_rst;
	logic i_bus_request;
	logic i_bus_rw;
	bus_addr_t i_bus_address;
	bus_data_t i_bus_wdata;
	bus_data_t o_bus_rdata;
	logic o_bus_ready;
	led_value_t o_leds;
	logic o_timer_interrupt;
	logic o_bus_fault;
	bus_addr_t o_fault_address;

	int check_errors;
	int protocol_errors;
	int cycles;
	logic [31:0] lfsr;

	// Reference model state
	bus_data_t model_ram [`SOC_RAM_WORDS];
	led_value_t model_leds;
	bus_data_t model_count;
	bus_data_t model_compare;
	bus_data_t model_read_count;
	logic model_irq;
	logic model_fault;
	bus_addr_t model_fault_address;
	logic prev_request;
	logic first_sample;
	logic timer_addressed;
	logic [2:0] timer_offset;

	soc_top UUT (
		.i_clock           (i_clock),
		.i_rst             (i_rst),
		.i_bus_request     (i_bus_request),
		.i_bus_rw          (i_bus_rw),
		.i_bus_address     (i_bus_address),
		.i_bus_wdata       (i_bus_wdata),
		.o_bus_rdata       (o_bus_rdata),
		.o_bus_ready       (o_bus_ready),
		.o_leds            (o_leds),
		.o_timer_interrupt (o_timer_interrupt),
		.o_bus_fault       (o_bus_fault),
		.o_fault_address   (o_fault_address)
	);

	always #10 i_clock = ~i_clock;

	//==========================================================================
	// Timer model following the bus as sampled at each edge
	//==========================================================================

	assign first_sample = i_bus_request && !prev_request;
	assign timer_addressed = (i_bus_address[31:28] == `SOC_REGION_TIMER);
	assign timer_offset = i_bus_address[4:2];

	always @(posedge i_clock) begin
		if (i_rst) begin
			model_count <= '0;
			model_compare <= '1;
			model_irq <= 1'b0;
			prev_request <= 1'b0;
		end else begin
			prev_request <= i_bus_request;
			model_irq <= (model_count >= model_compare);
			if (first_sample && timer_addressed && i_bus_rw && timer_offset == 3'd0)
				model_count <= i_bus_wdata;
			else
				model_count <= model_count + 1;
			if (first_sample && timer_addressed && i_bus_rw && timer_offset == 3'd1)
				model_compare <= i_bus_wdata;
			if (first_sample && timer_addressed && !i_bus_rw)
				model_read_count <= model_count;
		end
	end

	// Interrupt level every cycle
	always @(negedge i_clock) begin
		if (!i_rst)
			bit_check("o_timer_interrupt", o_timer_interrupt, model_irq);
	end

	always @(posedge i_clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	//==========================================================================
	// Random source and compare tasks
	//==========================================================================

	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic data_check(input string name, input bus_data_t got, input bus_data_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			check_errors++;
		end
	endtask

	task automatic leds_check(input string name, input led_value_t got, input led_value_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			check_errors++;
		end
	endtask

	task automatic addr_check(input string name, input bus_addr_t got, input bus_addr_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			check_errors++;
		end
	endtask

	task automatic bit_check(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			check_errors++;
		end
	endtask

	// One bus transfer with ready expected one cycle after the sample
	task automatic transfer(input logic rw, input bus_addr_t addr, input bus_data_t wdata,
			output bus_data_t rdata);
		int edges;
		@(posedge i_clock);
		i_bus_request <= 1'b1;
		i_bus_rw <= rw;
		i_bus_address <= addr;
		i_bus_wdata <= wdata;
		edges = 0;
		do begin
			@(negedge i_clock);
			edges++;
		end while (!o_bus_ready && edges < 8);
		if (edges != 2) begin
			$display("Ready for address %h came after %0d half-cycles instead of 2",
				addr, edges);
			protocol_errors++;
		end
		rdata = o_bus_rdata;
		@(posedge i_clock);
		i_bus_request <= 1'b0;
	endtask

	//==========================================================================
	// Stimulus
	//==========================================================================

	initial begin
		logic [31:0] kind;
		logic [31:0] rw_bit;
		logic [31:0] offset;
		logic [31:0] data;
		bus_addr_t addr;
		bus_data_t rdata;
		bus_data_t expected;

		i_clock = 1'b0;
		i_rst = 1'b1;
		i_bus_request = 1'b0;
		i_bus_rw = 1'b0;
		i_bus_address = '0;
		i_bus_wdata = '0;
		check_errors = 0;
		protocol_errors = 0;
		cycles = 0;
		lfsr = 32'd92863;
		model_leds = '0;
		model_fault = 1'b0;
		model_fault_address = '0;
		for (int i = 0; i < `SOC_RAM_WORDS; i++)
			model_ram[i] = '0;

		repeat (2) @(posedge i_clock);
		i_rst <= 1'b0;
		@(negedge i_clock);

		// Outputs right after reset
		bit_check("o_bus_ready", o_bus_ready, 1'b0);
		bit_check("o_bus_fault", o_bus_fault, 1'b0);
		addr_check("o_fault_address", o_fault_address, '0);
		leds_check("o_leds", o_leds, '0);
		bit_check("o_timer_interrupt", o_timer_interrupt, 1'b0);
		transfer(1'b0, 32'hA000_0004, '0, rdata);
		data_check("o_bus_rdata", rdata, '1);

		for (int t = 0; t < NUM_TRANSFERS; t++) begin
			kind = next_bits(2);
			rw_bit = next_bits(1);
			data = next_bits(32);
			case (kind[1:0])
				2'd0: begin
					offset = next_bits(9);
					addr = {4'h1, 17'd0, offset[8:0], 2'b00};
					transfer(rw_bit[0], addr, data, rdata);
					if (rw_bit[0])
						model_ram[offset[8:0]] = data;
					else
						data_check("o_bus_rdata", rdata, model_ram[offset[8:0]]);
				end
				2'd1: begin
					addr = 32'h4000_0000;
					transfer(rw_bit[0], addr, data, rdata);
					if (rw_bit[0])
						model_leds = data[`SOC_LED_WIDTH-1:0];
					else
						data_check("o_bus_rdata", rdata, '0);
				end
				2'd2: begin
					offset = next_bits(2);
					addr = {4'hA, 23'd0, offset[2:0], 2'b00};
					// Small values keep count and compare close
					if (offset[1:0] == 2'd0)
						data = data & 32'h0000_00FF;
					else
						data = data & 32'h0000_03FF;
					transfer(rw_bit[0], addr, data, rdata);
					if (!rw_bit[0]) begin
						if (offset[1:0] == 2'd0)
							expected = model_read_count;
						else if (offset[1:0] == 2'd1)
							expected = model_compare;
						else
							expected = '0;
						data_check("o_bus_rdata", rdata, expected);
					end
				end
				default: begin
					offset = next_bits(4);
					if (offset[3:0] == 4'h1 || offset[3:0] == 4'h4 || offset[3:0] == 4'hA)
						offset[3:0] = 4'h0;
					addr = {offset[3:0], data[27:0]};
					transfer(rw_bit[0], addr, data, rdata);
					if (!rw_bit[0])
						data_check("o_bus_rdata", rdata, '0);
					if (!model_fault) begin
						model_fault = 1'b1;
						model_fault_address = addr;
					end
				end
			endcase
			leds_check("o_leds", o_leds, model_leds);
			bit_check("o_bus_fault", o_bus_fault, model_fault);
			addr_check("o_fault_address", o_fault_address, model_fault_address);
		end

		repeat (2) @(posedge i_clock);
		$display("Error counts: checks %0d, protocol %0d", check_errors, protocol_errors);
		if (check_errors == 0 && protocol_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+design
design/soc_bus_pkg.sv
design/soc_bus_decode.sv
design/soc_ram.sv
design/soc_led.sv
design/soc_timer.sv
design/soc_bus_return.sv
design/soc_top.sv
verif/soc_checker.sv
verif/soc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= soc_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
